// File: flist.f
+incdir+tb
hdl/cpu_pkg.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/fetch_stage.sv
hdl/execute_stage.sv
hdl/processor.sv
tb/tb_processor.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f flist.f --top-module tb_processor --Mdir obj_dir
out=$(./obj_dir/Vtb_processor 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// File: tb/isa_model.svh
// instruction-level reference model and random program generator
// included inside tb_processor after cpu_pkg is imported; forward branches only
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

typedef struct packed {
    reg_idx_t idx;
    word_t    value;
} reg_write_t;

typedef struct packed {
    word_t address;
    word_t value;
} mem_write_t;

localparam int prog_len   = 200;
localparam int imem_words = 256;
localparam int dmem_words = 4096;

word_t      lcg_state = 32'd41337;
int         gen_idx;
logic       model_done;
word_t      prog [0:imem_words-1];
word_t      init_regs [0:31];
word_t      model_regs [0:31];
word_t      model_dmem [0:dmem_words-1];
reg_write_t exp_reg_q [$];
mem_write_t exp_mem_q [$];

function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// upper bits are the better ones
function automatic word_t rand_below(word_t n);
    word_t r;
    r = lcg_next();
    return (r >> 16) % n;
endfunction

// initial data memory contents, every address bit matters
function automatic word_t fill_word(word_t addr);
    return (addr * 32'h9e37_79b1) ^ (addr << 20) ^ 32'h5a3c_0000;
endfunction

// small pool so dependencies are dense; r0 and r31 now and then
function automatic reg_idx_t pick_src();
    word_t v;
    v = rand_below(16);
    if (v == 0) begin
        return '0;
    end
    if (v == 1) begin
        return link_reg;
    end
    return reg_idx_t'(32'd4 + v % 32'd8);
endfunction

function automatic reg_idx_t pick_dest();
    word_t v;
    v = rand_below(16);
    if (v == 0) begin
        return '0;
    end
    return reg_idx_t'(32'd4 + v % 32'd8);
endfunction

function automatic alu_op_t pick_alu_op();
    case (rand_below(6))
        0: return alu_add;
        1: return alu_sub;
        2: return alu_and;
        3: return alu_or;
        4: return alu_sll;
        default: return alu_sra;
    endcase
endfunction

function automatic word_t encode_rtype(reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                       logic [4:0] shamt, alu_op_t op);
    return {op_rtype, rd, rs, rt, shamt, op, 2'b00};
endfunction

function automatic word_t encode_itype(opcode_t op, reg_idx_t rd, reg_idx_t rs,
                                       logic [16:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic word_t encode_jump(opcode_t op, word_t target);
    return {op, target[26:0]};
endfunction

// 1 to 4 slots ahead, never past the final self-loop
function automatic word_t forward_target();
    word_t t;
    t = word_t'(gen_idx) + 32'd1 + rand_below(4);
    if (t > word_t'(prog_len - 1)) begin
        t = word_t'(prog_len - 1);
    end
    return t;
endfunction

task automatic emit(word_t instr);
    prog[gen_idx[7:0]] = instr;
    gen_idx = gen_idx + 1;
endtask

task automatic generate_program();
    word_t    kind;
    word_t    t;
    reg_idx_t base;
    reg_idx_t dst;
    reg_idx_t ra;
    reg_idx_t rb;
    logic [16:0] off;
    for (int i = 0; i < 32; i++) begin
        init_regs[i[4:0]] = lcg_next();
    end
    init_regs[0] = '0;
    // r1..r3 are the memory base registers, kept small
    for (int i = 1; i < 4; i++) begin
        init_regs[i[4:0]] = init_regs[i[4:0]] & 32'h0000_00ff;
    end
    for (int i = 0; i < imem_words; i++) begin
        prog[i[7:0]] = '0;
    end
    gen_idx = 0;
    while (gen_idx < prog_len - 1) begin
        kind = rand_below(10);
        dst  = pick_dest();
        if (kind == 4 && gen_idx + 3 < prog_len) begin
            // set base, store, load the same word back
            base = reg_idx_t'(32'd1 + rand_below(3));
            off  = 17'(rand_below(64));
            emit(encode_itype(op_addi, base, '0, 17'(rand_below(256))));
            emit(encode_itype(op_sw, pick_src(), base, off));
            emit(encode_itype(op_lw, dst, base, off));
        end else if (kind == 5 && gen_idx + 2 < prog_len) begin
            // load-use pair, or the loaded value stored straight back
            base = reg_idx_t'(32'd1 + rand_below(3));
            emit(encode_itype(op_lw, dst, base, 17'(rand_below(64))));
            if (rand_below(2) == 0) begin
                emit(encode_rtype(pick_dest(), dst, pick_src(), 5'd0, alu_add));
            end else begin
                emit(encode_itype(op_sw, dst, base, 17'(rand_below(64))));
            end
        end else if (kind == 6 || kind == 7) begin
            t  = forward_target();
            ra = pick_src();
            // same register now and then, so bne falls through
            rb = (rand_below(3) == 0) ? ra : pick_src();
            emit(encode_itype(kind == 6 ? op_bne : op_blt, ra, rb,
                              17'(t - word_t'(gen_idx) - 32'd1)));
        end else if (kind == 8 || kind == 9) begin
            t = forward_target();
            emit(encode_jump(kind == 8 ? op_j : op_jal, t));
        end else if (kind == 3 || kind == 4 || kind == 5) begin
            emit(encode_itype(op_addi, dst, pick_src(), 17'(lcg_next())));
        end else begin
            emit(encode_rtype(dst, pick_src(), pick_src(), 5'(rand_below(32)), pick_alu_op()));
        end
    end
    // final self-loop
    emit(encode_jump(op_j, word_t'(prog_len - 1)));
endtask

function automatic word_t alu_model(alu_op_t op, word_t a, word_t b, logic [4:0] sh);
    case (op)
        alu_add: return a + b;
        alu_sub: return a - b;
        alu_and: return a & b;
        alu_or:  return a | b;
        alu_sll: return a << sh;
        alu_sra: return word_t'($signed(a) >>> sh);
        default: return '0;
    endcase
endfunction

// r0 writes are dropped, as in the ISA
task automatic record_reg_write(reg_idx_t r, word_t v);
    reg_write_t w;
    if (r != '0) begin
        model_regs[r] = v;
        w.idx = r;
        w.value = v;
        exp_reg_q.push_back(w);
    end
endtask

task automatic run_model();
    word_t      pc;
    word_t      next;
    word_t      instr;
    word_t      imm;
    word_t      addr;
    opcode_t    op;
    reg_idx_t   rd;
    reg_idx_t   rs;
    reg_idx_t   rt;
    mem_write_t m;
    int         steps;
    for (int i = 0; i < 32; i++) begin
        model_regs[i[4:0]] = init_regs[i[4:0]];
    end
    for (int i = 0; i < dmem_words; i++) begin
        model_dmem[i[11:0]] = fill_word(word_t'(i));
    end
    pc = '0;
    steps = 0;
    model_done = 1'b0;
    while (!model_done && steps < prog_len * 2) begin
        instr = prog[pc[7:0]];
        op    = instr[31:27];
        rd    = instr[26:22];
        rs    = instr[21:17];
        rt    = instr[16:12];
        imm   = {{15{instr[16]}}, instr[16:0]};
        addr  = model_regs[rs] + imm;
        next  = pc + 32'd1;
        steps = steps + 1;
        case (op)
            op_rtype: record_reg_write(rd, alu_model(instr[6:2], model_regs[rs],
                                                     model_regs[rt], instr[11:7]));
            op_addi:  record_reg_write(rd, addr);
            op_lw:    record_reg_write(rd, model_dmem[addr[11:0]]);
            op_sw: begin
                model_dmem[addr[11:0]] = model_regs[rd];
                m.address = addr;
                m.value = model_regs[rd];
                exp_mem_q.push_back(m);
            end
            op_bne: begin
                if (model_regs[rd] != model_regs[rs]) begin
                    next = pc + 32'd1 + imm;
                end
            end
            op_blt: begin
                if ($signed(model_regs[rd]) < $signed(model_regs[rs])) begin
                    next = pc + 32'd1 + imm;
                end
            end
            op_jal: begin
                record_reg_write(link_reg, pc + 32'd1);
                next = {5'b0, instr[26:0]};
            end
            op_j: begin
                if ({5'b0, instr[26:0]} == pc) begin
                    model_done = 1'b1;
                end
                next = {5'b0, instr[26:0]};
            end
            default: begin
                next = pc + 32'd1;
            end
        endcase
        pc = next;
    end
endtask

`endif

// File: tb/tb_processor.sv
// testbench for the five-stage core with behavioral memories and register file
// random program from a fixed seed; register and memory writes checked in order
// passes when every expected write matched and the core then stays quiet
`timescale 1ns/1ns
module tb_processor;
    import cpu_pkg::*;

    `include "isa_model.svh"

    localparam int idle_cycles    = 20;
    localparam int timeout_cycles = prog_len * 4 + 100;

    logic     clock;
    logic     reset;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_writeEnable;
    reg_idx_t ctrl_writeReg;
    reg_idx_t ctrl_readRegA;
    reg_idx_t ctrl_readRegB;
    word_t    data_writeReg;
    word_t    data_readRegA;
    word_t    data_readRegB;
    int       cycles_after_reset;
    word_t    dmem [0:dmem_words-1];
    word_t    rf [0:31];

    processor processor_i (
        .clock            (clock),
        .reset            (reset),
        .address_imem     (address_imem),
        .q_imem           (q_imem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .ctrl_readRegA    (ctrl_readRegA),
        .ctrl_readRegB    (ctrl_readRegB),
        .data_writeReg    (data_writeReg),
        .data_readRegA    (data_readRegA),
        .data_readRegB    (data_readRegB)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h",
                                        $time, name, actual, expected));
        end
    endtask

    // combinational reads, beyond the program the imem reads zero (nop)
    assign q_imem        = (address_imem < word_t'(imem_words)) ? prog[address_imem[7:0]] : '0;
    assign q_dmem        = dmem[address_dmem[11:0]];
    assign data_readRegA = rf[ctrl_readRegA];
    assign data_readRegB = rf[ctrl_readRegB];

    // rising-edge writes, r0 stays zero
    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[11:0]] <= data;
        end
        if (ctrl_writeEnable && ctrl_writeReg != '0) begin
            rf[ctrl_writeReg] <= data_writeReg;
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            cycles_after_reset <= 0;
        end else if (cycles_after_reset < 3) begin
            cycles_after_reset <= cycles_after_reset + 1;
        end
    end

    // sampled mid-cycle, values that commit at the next rising edge
    always @(negedge clock) begin
        reg_write_t exp_reg;
        mem_write_t exp_mem;
        // pipeline still filling, pc counts up from 0
        if (reset || cycles_after_reset < 3) begin
            check_equal("wren", word_t'(wren), '0);
            check_equal("ctrl_writeEnable", word_t'(ctrl_writeEnable), '0);
            check_equal("address_imem", address_imem, word_t'(cycles_after_reset));
        end
        if (ctrl_writeEnable) begin
            if (exp_reg_q.size() == 0) begin
                stop_with_failure($sformatf("register write to r%0d that the model never made",
                                            ctrl_writeReg));
            end else begin
                exp_reg = exp_reg_q.pop_front();
                check_equal("ctrl_writeReg", word_t'(ctrl_writeReg), word_t'(exp_reg.idx));
                check_equal("data_writeReg", data_writeReg, exp_reg.value);
            end
        end
        if (wren) begin
            if (exp_mem_q.size() == 0) begin
                stop_with_failure($sformatf("memory write to 0x%08h that the model never made",
                                            address_dmem));
            end else begin
                exp_mem = exp_mem_q.pop_front();
                check_equal("address_dmem", address_dmem, exp_mem.address);
                check_equal("data", data, exp_mem.value);
            end
        end
    end

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clock);
        stop_with_failure($sformatf("watchdog timeout, %0d register and %0d memory writes missing",
                                    exp_reg_q.size(), exp_mem_q.size()));
    end

    initial begin
        reset = 1'b1;
        generate_program();
        run_model();
        for (int i = 0; i < 32; i++) begin
            rf[i[4:0]] <= init_regs[i[4:0]];
        end
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i[11:0]] <= fill_word(word_t'(i));
        end
        if (!model_done) begin
            stop_with_failure("reference model never reached the final self-loop");
        end
        $display("expecting %0d register writes and %0d memory writes",
                 exp_reg_q.size(), exp_mem_q.size());
        repeat (5) @(posedge clock);
        #1 reset = 1'b0;
        while (exp_reg_q.size() != 0 || exp_mem_q.size() != 0) begin
            @(posedge clock);
        end
        // self-loop reached, no write may follow
        repeat (idle_cycles) @(posedge clock);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: hdl/processor.sv
// five-stage pipelined core, memories and register file are external
// imem, dmem and regfile read combinationally; regfile writes on the rising edge
// taken branch or jump costs two bubbles, load-use costs one
`timescale 1ns/1ns
module processor (
    input  logic           clock,
    input  logic           reset,
    // instruction memory
    output cpu_pkg::word_t address_imem,
    input  cpu_pkg::word_t q_imem,
    // data memory
    output cpu_pkg::word_t address_dmem,
    output cpu_pkg::word_t data,
    output logic           wren,
    input  cpu_pkg::word_t q_dmem,
    // register file
    output logic             ctrl_writeEnable,
    output cpu_pkg::reg_idx_t ctrl_writeReg,
    output cpu_pkg::reg_idx_t ctrl_readRegA,
    output cpu_pkg::reg_idx_t ctrl_readRegB,
    output cpu_pkg::word_t    data_writeReg,
    input  cpu_pkg::word_t    data_readRegA,
    input  cpu_pkg::word_t    data_readRegB
);
    import cpu_pkg::*;

    word_t    pc;
    word_t    fd_pc;
    word_t    fd_instr;
    ctrl_t    dec_ctrl;
    word_t    dec_imm;
    word_t    dec_target;
    word_t    ex_result;
    word_t    store_val;
    word_t    redirect_pc;
    word_t    wb_data;
    logic     redirect;
    logic     stall;
    logic     store_fwd;
    logic     dec_fwd_a;
    logic     dec_fwd_b;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    dx_t      dx_d;
    dx_t      dx_q;
    xm_t      xm_d;
    xm_t      xm_q;
    mw_t      mw_d;
    mw_t      mw_q;

    // fetch
    fetch_stage fetch_stage_i (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_in    (q_imem),
        .pc          (pc),
        .fd_pc       (fd_pc),
        .fd_instr    (fd_instr)
    );

    assign address_imem = pc;

    // decode
    instr_decoder instr_decoder_i (
        .instr  (fd_instr),
        .ctrl   (dec_ctrl),
        .imm    (dec_imm),
        .target (dec_target)
    );

    assign ctrl_readRegA = dec_ctrl.src_a;
    assign ctrl_readRegB = dec_ctrl.src_b;

    hazard_unit hazard_unit_i (
        .dx        (dx_q),
        .xm        (xm_q),
        .mw        (mw_q),
        .dec_ctrl  (dec_ctrl),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .store_fwd (store_fwd),
        .dec_fwd_a (dec_fwd_a),
        .dec_fwd_b (dec_fwd_b),
        .stall     (stall)
    );

    // decode/execute input, bubble on stall or flush
    always_comb begin
        dx_d.pc     = fd_pc;
        dx_d.rs_val = dec_fwd_a ? wb_data : data_readRegA;
        dx_d.rt_val = dec_fwd_b ? wb_data : data_readRegB;
        dx_d.imm    = dec_imm;
        dx_d.target = dec_target;
        dx_d.ctrl   = (stall || redirect) ? nop_ctrl : dec_ctrl;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dx_q.ctrl <= nop_ctrl;
        end else begin
            dx_q <= dx_d;
        end
    end

    // execute
    execute_stage execute_stage_i (
        .dx          (dx_q),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .mem_val     (xm_q.result),
        .wb_val      (wb_data),
        .result      (ex_result),
        .store_val   (store_val),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // execute/memory, the branch itself always moves on
    assign xm_d = '{result: ex_result, store_data: store_val, ctrl: dx_q.ctrl};

    always_ff @(posedge clock) begin
        if (reset) begin
            xm_q.ctrl <= nop_ctrl;
        end else begin
            xm_q <= xm_d;
        end
    end

    // memory, alu result is the address
    assign address_dmem = xm_q.result;
    assign data         = store_fwd ? wb_data : xm_q.store_data;
    assign wren         = xm_q.ctrl.mem_write;

    assign mw_d = '{result: xm_q.result, load_data: q_dmem, ctrl: xm_q.ctrl};

    always_ff @(posedge clock) begin
        if (reset) begin
            mw_q.ctrl <= nop_ctrl;
        end else begin
            mw_q <= mw_d;
        end
    end

    // writeback
    assign wb_data          = mw_q.ctrl.mem_read ? mw_q.load_data : mw_q.result;
    assign ctrl_writeEnable = mw_q.ctrl.reg_write;
    assign ctrl_writeReg    = mw_q.ctrl.dest;
    assign data_writeReg    = wb_data;

endmodule

// File: hdl/execute_stage.sv
// execute stage, purely combinational
// bne/blt compare port b (rd) with port a (rs); blt taken when rd < rs
`timescale 1ns/1ns
module execute_stage (
    input  cpu_pkg::dx_t      dx,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    input  cpu_pkg::word_t    mem_val,
    input  cpu_pkg::word_t    wb_val,
    output cpu_pkg::word_t    result,
    output cpu_pkg::word_t    store_val,
    output logic              redirect,
    output cpu_pkg::word_t    redirect_pc
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_out;
    word_t pc_plus_one;
    word_t branch_pc;
    logic  not_equal;
    logic  less_than;
    logic  branch_taken;

    // operand a bypass
    always_comb begin
        case (fwd_a)
            fwd_mem: op_a = mem_val;
            fwd_wb:  op_a = wb_val;
            default: op_a = dx.rs_val;
        endcase
    end

    // operand b bypass, before the immediate mux
    always_comb begin
        case (fwd_b)
            fwd_mem: op_b_reg = mem_val;
            fwd_wb:  op_b_reg = wb_val;
            default: op_b_reg = dx.rt_val;
        endcase
    end

    assign op_b      = dx.ctrl.use_imm ? dx.imm : op_b_reg;
    // sw data is the bypassed port b value
    assign store_val = op_b_reg;

    alu alu_i (
        .a         (op_a),
        .b         (op_b),
        .op        (dx.ctrl.alu_op),
        .shamt     (dx.ctrl.shamt),
        .result    (alu_out),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // branch target relative to the next pc
    assign pc_plus_one = dx.pc + word_t'(1);
    assign branch_pc   = pc_plus_one + dx.imm;

    // less_than means rs < rd, so blt wants the opposite with inequality
    assign branch_taken = (dx.ctrl.is_bne && not_equal) ||
                          (dx.ctrl.is_blt && not_equal && !less_than);

    assign redirect    = branch_taken || dx.ctrl.is_jump || dx.ctrl.is_jal;
    assign redirect_pc = branch_taken ? branch_pc : dx.target;

    // jal links pc+1
    assign result = dx.ctrl.is_jal ? pc_plus_one : alu_out;

endmodule

// File: hdl/fetch_stage.sv
// program counter and fetch/decode register
// redirect beats stall; a flushed slot holds the zero instruction (a nop)
`timescale 1ns/1ns
module fetch_stage (
    input  logic           clock,
    input  logic           reset,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::word_t instr_in,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t fd_pc,
    output cpu_pkg::word_t fd_instr
);
    import cpu_pkg::*;

    word_t pc_next;

    // next pc choice
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + word_t'(1);
        end
    end

    // pc and fetched instruction
    always_ff @(posedge clock) begin
        if (reset) begin
            pc       <= '0;
            fd_instr <= '0;
        end else begin
            pc <= pc_next;
            if (redirect) begin
                // squash the wrong-path fetch
                fd_instr <= '0;
            end else if (!stall) begin
                fd_instr <= instr_in;
            end
        end
    end

    // pc travels with its instruction
    always_ff @(posedge clock) begin
        if (redirect || !stall) begin
            fd_pc <= pc;
        end
    end

endmodule

// File: hdl/hazard_unit.sv
// forwarding and load-use detection, purely combinational
// a load in memory never forwards its address; sw data is caught later instead
`timescale 1ns/1ns
module hazard_unit (
    input  cpu_pkg::dx_t      dx,
    input  cpu_pkg::xm_t      xm,
    input  cpu_pkg::mw_t      mw,
    input  cpu_pkg::ctrl_t    dec_ctrl,
    output cpu_pkg::fwd_sel_t fwd_a,
    output cpu_pkg::fwd_sel_t fwd_b,
    output logic              store_fwd,
    output logic              dec_fwd_a,
    output logic              dec_fwd_b,
    output logic              stall
);
    import cpu_pkg::*;

    logic xm_can_fwd;

    // producer c writes register r, r0 excluded
    function automatic logic hits(ctrl_t c, reg_idx_t r);
        return c.reg_write && (c.dest != '0) && (c.dest == r);
    endfunction

    // loaded data not ready in memory stage
    assign xm_can_fwd = !xm.ctrl.mem_read;

    // execute operand a, newest producer first
    always_comb begin
        if (xm_can_fwd && hits(xm.ctrl, dx.ctrl.src_a)) begin
            fwd_a = fwd_mem;
        end else if (hits(mw.ctrl, dx.ctrl.src_a)) begin
            fwd_a = fwd_wb;
        end else begin
            fwd_a = fwd_reg;
        end
    end

    // execute operand b, same priority
    always_comb begin
        if (xm_can_fwd && hits(xm.ctrl, dx.ctrl.src_b)) begin
            fwd_b = fwd_mem;
        end else if (hits(mw.ctrl, dx.ctrl.src_b)) begin
            fwd_b = fwd_wb;
        end else begin
            fwd_b = fwd_reg;
        end
    end

    // sw in memory, data produced by the instruction right before it
    assign store_fwd = xm.ctrl.mem_write && hits(mw.ctrl, xm.ctrl.src_b);

    // regfile writes at the edge, so decode sees the old value without this
    assign dec_fwd_a = hits(mw.ctrl, dec_ctrl.src_a);
    assign dec_fwd_b = hits(mw.ctrl, dec_ctrl.src_b);

    // load in execute feeding decode
    // sw store data is exempt, store_fwd covers it two stages on
    assign stall = dx.ctrl.mem_read &&
                   (hits(dx.ctrl, dec_ctrl.src_a) ||
                    (hits(dx.ctrl, dec_ctrl.src_b) && !dec_ctrl.mem_write));

endmodule

// File: hdl/alu.sv
// integer alu for the execute stage
// flags compare a against b regardless of op; unknown ops give zero
`timescale 1ns/1ns
module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    input  logic [4:0]       shamt,
    output cpu_pkg::word_t   result,
    output logic             not_equal,
    output logic             less_than
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            // shifts use the shamt field, not b
            alu_sll: result = a << shamt;
            alu_sra: result = word_t'($signed(a) >>> shamt);
            default: result = '0;
        endcase
    end

    // branch flags
    assign not_equal = (a != b);
    // signed compare, no overflow path needed
    assign less_than = ($signed(a) < $signed(b));

endmodule

// File: hdl/instr_decoder.sv
// decode-stage instruction decoder, purely combinational
// unknown opcodes decode as a bubble; writes to r0 are suppressed here
`timescale 1ns/1ns
module instr_decoder (
    input  cpu_pkg::word_t instr,
    output cpu_pkg::ctrl_t ctrl,
    output cpu_pkg::word_t imm,
    output cpu_pkg::word_t target
);
    import cpu_pkg::*;

    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    logic     writes;

    // raw fields
    assign opcode = instr[opcode_lsb +: $bits(opcode_t)];
    assign rd     = instr[rd_lsb +: $bits(reg_idx_t)];
    assign rs     = instr[rs_lsb +: $bits(reg_idx_t)];
    assign rt     = instr[rt_lsb +: $bits(reg_idx_t)];

    // sign-extended immediate, zero-extended jump target
    assign imm    = {{(word_width - imm_width){instr[imm_width-1]}}, instr[imm_width-1:0]};
    assign target = {{(word_width - target_width){1'b0}}, instr[target_width-1:0]};

    always_comb begin
        ctrl        = nop_ctrl;
        writes      = 1'b0;
        ctrl.shamt  = instr[shamt_lsb +: 5];
        // non r-type ops only ever need add
        ctrl.alu_op = alu_add;
        ctrl.dest   = rd;
        case (opcode)
            op_rtype: begin
                writes      = 1'b1;
                ctrl.alu_op = instr[aluop_lsb +: $bits(alu_op_t)];
                ctrl.src_a  = rs;
                ctrl.src_b  = rt;
            end
            op_addi: begin
                writes       = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.src_a   = rs;
            end
            op_lw: begin
                writes        = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.src_a    = rs;
            end
            op_sw: begin
                // rd carries the store data on port b
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.src_a     = rs;
                ctrl.src_b     = rd;
            end
            op_j: begin
                ctrl.is_jump = 1'b1;
            end
            op_jal: begin
                writes      = 1'b1;
                ctrl.is_jal = 1'b1;
                ctrl.dest   = link_reg;
            end
            op_bne: begin
                ctrl.is_bne = 1'b1;
                ctrl.src_a  = rs;
                ctrl.src_b  = rd;
            end
            op_blt: begin
                ctrl.is_blt = 1'b1;
                ctrl.src_a  = rs;
                ctrl.src_b  = rd;
            end
            default: begin
                // treated as a bubble
                writes = 1'b0;
            end
        endcase
        // r0 never written, so a zero instruction is a true nop
        ctrl.reg_write = writes && (ctrl.dest != '0);
    end

endmodule

// File: hdl/cpu_pkg.sv
// shared types and constants for the five-stage core
// 32-bit words, word-addressed memories, no exceptions or multiply/divide
package cpu_pkg;

    // base widths
    localparam int word_width = 32;

    typedef logic [word_width-1:0] word_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [4:0]            opcode_t;
    typedef logic [4:0]            alu_op_t;
    // execute operand source
    typedef logic [1:0]            fwd_sel_t;

    // opcodes
    localparam opcode_t op_rtype = 5'b00000;
    localparam opcode_t op_j     = 5'b00001;
    localparam opcode_t op_bne   = 5'b00010;
    localparam opcode_t op_jal   = 5'b00011;
    localparam opcode_t op_addi  = 5'b00101;
    localparam opcode_t op_blt   = 5'b00110;
    localparam opcode_t op_sw    = 5'b00111;
    localparam opcode_t op_lw    = 5'b01000;

    // r-type alu ops
    localparam alu_op_t alu_add = 5'b00000;
    localparam alu_op_t alu_sub = 5'b00001;
    localparam alu_op_t alu_and = 5'b00010;
    localparam alu_op_t alu_or  = 5'b00011;
    localparam alu_op_t alu_sll = 5'b00100;
    localparam alu_op_t alu_sra = 5'b00101;

    // instruction field positions
    localparam int opcode_lsb   = 27;
    localparam int rd_lsb       = 22;
    localparam int rs_lsb       = 17;
    localparam int rt_lsb       = 12;
    localparam int shamt_lsb    = 7;
    localparam int aluop_lsb    = 2;
    localparam int imm_width    = 17;
    localparam int target_width = 27;

    // jal destination
    localparam reg_idx_t link_reg = 5'd31;

    // forwarding select encodings
    localparam fwd_sel_t fwd_reg = 2'd0;
    localparam fwd_sel_t fwd_wb  = 2'd1;
    localparam fwd_sel_t fwd_mem = 2'd2;

    // decoded controls, carried down the pipe
    typedef struct packed {
        logic       reg_write;
        logic       use_imm;
        alu_op_t    alu_op;
        logic [4:0] shamt;
        reg_idx_t   dest;
        logic       mem_write;
        logic       mem_read;
        logic       is_jump;
        logic       is_jal;
        logic       is_bne;
        logic       is_blt;
        reg_idx_t   src_a;
        reg_idx_t   src_b;
    } ctrl_t;

    // bubble, writes nothing and redirects nothing
    localparam ctrl_t nop_ctrl = '0;

    typedef struct packed {
        word_t pc;
        word_t rs_val;
        word_t rt_val;
        word_t imm;
        word_t target;
        ctrl_t ctrl;
    } dx_t;

    typedef struct packed {
        word_t result;
        word_t store_data;
        ctrl_t ctrl;
    } xm_t;

    typedef struct packed {
        word_t result;
        word_t load_data;
        ctrl_t ctrl;
    } mw_t;

endpackage
